// ==== Bender.yml ====
package:
  name: spi_card

export_include_dirs:
  - .

sources:
  - spi_card_pkg.sv
  - spi_bus_regs.sv
  - spi_clk_gen.sv
  - spi_shifter.sv
  - spi_card_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_card_model.sv
      - tb_spi_card.sv

// ==== spi_bus_regs.sv ====
`timescale 1ns/1ps
`include "spi_card_cfg.svh"

module spi_bus_regs (
  input  logic                    int_clk,
  input  logic                    arst_n,
  input  spi_card_pkg::bus_req_t  bus_req,
  input  logic                    busy,
  input  spi_card_pkg::byte_t     rx_data,
  output spi_card_pkg::xfer_ctl_t xfer_ctl,
  output logic                    slow,
  output logic                    card_cs_n,
  output spi_card_pkg::byte_t     rdata,
  output logic                    d_oe,
  output logic                    n_rdy
);

  import spi_card_pkg::*;

  logic  wr_en;
  logic  rd_en;
  logic  hit_data;
  logic  hit_ctrl;
  logic  cs_on;
  logic  launch;
  logic  start_q;
  byte_t tx_q;
  byte_t status;

  // strobe decode
  assign wr_en = ~bus_req.n_sel & ~bus_req.n_we;
  assign rd_en = ~bus_req.n_sel & ~bus_req.n_oe;

  assign hit_data = (bus_req.addr == 1'(`SPI_ADDR_DATA));
  assign hit_ctrl = (bus_req.addr == 1'(`SPI_ADDR_CTRL));

  // control register, card deselected and slow clock out of reset
  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      cs_on <= 1'b0;
      slow  <= 1'b1;
    end else if (wr_en && hit_ctrl) begin
      cs_on <= bus_req.wdata[0];
      slow  <= bus_req.wdata[1];
    end
  end

  assign card_cs_n = ~cs_on;

  // data writes during a transfer are dropped
  // start_q also blocks a second launch while the strobe is held
  assign launch = wr_en & hit_data & ~busy & ~start_q;

  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= launch;
    end
  end

  always_ff @(posedge int_clk) begin
    if (launch) begin
      tx_q <= bus_req.wdata;  // byte travels with the start pulse
    end
  end

  assign xfer_ctl.start   = start_q;
  assign xfer_ctl.tx_data = tx_q;

  // status layout: busy in bit 7, slow in bit 1, cs_on in bit 0
  assign status = {busy, 5'b0_0000, slow, cs_on};

  // read path
  always_comb begin
    rdata = '0;
    if (rd_en) begin
      if (hit_data) begin
        rdata = rx_data;
      end else begin
        rdata = status;
      end
    end
  end

  assign d_oe = rd_en;

  // wait request only while the bus is on us
  assign n_rdy = busy & ~bus_req.n_sel;

endmodule

// ==== spi_card_cfg.svh ====
`ifndef SPI_CARD_CFG_SVH
`define SPI_CARD_CFG_SVH

// half sck period in int_clk cycles
`define SPI_DIV_FAST 2

// slow clock for card start-up
`define SPI_DIV_SLOW 8

// register map
`define SPI_ADDR_DATA 0

`define SPI_ADDR_CTRL 1

`endif

// ==== spi_card_pkg.sv ====
package spi_card_pkg;

  // one byte on the processor bus and on the wire
  typedef logic [7:0] byte_t;

  // counts sck falls, 0 to 8
  typedef logic [3:0] bit_cnt_t;

  // half period divider count
  typedef logic [7:0] div_cnt_t;

  // processor bus request, strobes active low
  typedef struct packed {
    logic  n_sel;
    logic  n_we;
    logic  n_oe;
    logic  addr;   // 0 data, 1 control/status
    byte_t wdata;
  } bus_req_t;

  // register block to shifter
  typedef struct packed {
    logic  start;    // single cycle
    byte_t tx_data;
  } xfer_ctl_t;

  // clock generator to shifter
  typedef struct packed {
    logic rise;
    logic fall;
  } sck_evt_t;

endpackage

// ==== spi_card_top.sv ====
`timescale 1ns/1ps

module spi_card_top (
  input  logic                   int_clk,
  input  logic                   arst_n,
  input  spi_card_pkg::bus_req_t bus_req,
  input  logic                   miso,
  output logic                   sck,
  output logic                   mosi,
  output logic                   card_cs_n,
  output spi_card_pkg::byte_t    rdata,
  output logic                   d_oe,
  output logic                   n_rdy
);

  import spi_card_pkg::*;

  xfer_ctl_t xfer_ctl;
  sck_evt_t  sck_evt;
  byte_t     rx_data;
  logic      busy;
  logic      slow;

  // processor side
  spi_bus_regs regs_i (
    .int_clk   (int_clk),
    .arst_n    (arst_n),
    .bus_req   (bus_req),
    .busy      (busy),
    .rx_data   (rx_data),
    .xfer_ctl  (xfer_ctl),
    .slow      (slow),
    .card_cs_n (card_cs_n),
    .rdata     (rdata),
    .d_oe      (d_oe),
    .n_rdy     (n_rdy)
  );

  // sck timing
  spi_clk_gen clk_gen_i (
    .int_clk (int_clk),
    .arst_n  (arst_n),
    .busy    (busy),
    .slow    (slow),
    .sck_evt (sck_evt),
    .sck     (sck)
  );

  // card side data path
  spi_shifter shifter_i (
    .int_clk  (int_clk),
    .arst_n   (arst_n),
    .xfer_ctl (xfer_ctl),
    .sck_evt  (sck_evt),
    .miso     (miso),
    .mosi     (mosi),
    .busy     (busy),
    .rx_data  (rx_data)
  );

endmodule

// ==== spi_clk_gen.sv ====
`timescale 1ns/1ps
`include "spi_card_cfg.svh"

module spi_clk_gen (
  input  logic                   int_clk,
  input  logic                   arst_n,
  input  logic                   busy,
  input  logic                   slow,
  output spi_card_pkg::sck_evt_t sck_evt,
  output logic                   sck
);

  import spi_card_pkg::*;

  logic     busy_q;
  logic     load;      // first busy cycle
  logic     slow_q;
  logic     use_slow;
  logic     phase;     // low when the next pulse is a rise
  logic     tick;
  div_cnt_t div_cnt;
  div_cnt_t div_lim;

  assign load     = busy & ~busy_q;
  assign use_slow = load ? slow : slow_q;  // held for the whole transfer
  assign div_lim  = use_slow ? div_cnt_t'(`SPI_DIV_SLOW) : div_cnt_t'(`SPI_DIV_FAST);
  assign tick     = busy & (div_cnt == div_lim - 1'b1);

  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      slow_q <= 1'b1;
    end else begin
      busy_q <= busy;
      if (load) slow_q <= slow;
    end
  end

  // half period counter, idle keeps it parked at zero
  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      phase   <= 1'b0;
      sck     <= 1'b0;
    end else if (!busy) begin
      div_cnt <= '0;
      phase   <= 1'b0;
      sck     <= 1'b0;
    end else if (tick) begin
      div_cnt <= '0;
      phase   <= ~phase;
      sck     <= ~phase;  // high after a rise, low after a fall
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign sck_evt.rise = tick & ~phase;
  assign sck_evt.fall = tick & phase;

endmodule

// ==== spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter (
  input  logic                    int_clk,
  input  logic                    arst_n,
  input  spi_card_pkg::xfer_ctl_t xfer_ctl,
  input  spi_card_pkg::sck_evt_t  sck_evt,
  input  logic                    miso,
  output logic                    mosi,
  output logic                    busy,
  output spi_card_pkg::byte_t     rx_data
);

  import spi_card_pkg::*;

  byte_t    tx_sr;
  byte_t    rx_sr;
  bit_cnt_t bit_cnt;
  logic     load;
  logic     shift;
  logic     sample;
  logic     done;

  assign load   = xfer_ctl.start & ~busy;
  assign shift  = busy & sck_evt.fall;
  assign sample = busy & sck_evt.rise;

  // eighth fall, count goes to 8 on this edge
  assign done = shift & (bit_cnt == bit_cnt_t'(7));

  // msb first, next bit appears after each fall
  assign mosi = tx_sr[7];

  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
    end else if (load) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (load) begin
      bit_cnt <= '0;
    end else if (shift) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // tx register, zero fill leaves mosi low once the byte is out
  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_sr <= '0;
    end else if (load) begin
      tx_sr <= xfer_ctl.tx_data;
    end else if (shift) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  // miso sampled on sck rising
  always_ff @(posedge int_clk) begin
    if (sample) begin
      rx_sr <= {rx_sr[6:0], miso};
    end
  end

  always_ff @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_data <= '0;
    end else if (done) begin
      rx_data <= rx_sr;  // same cycle busy drops
    end
  end

endmodule

// ==== tb_card_model.sv ====
`timescale 1ns/1ps

module tb_card_model (
  input  logic       sck,
  input  logic       mosi,
  input  logic       card_cs_n,
  input  logic [7:0] script_byte,
  output logic       miso,
  output int         log_cnt,
  output logic [7:0] last_byte
);

  logic [7:0] in_sr = '0;
  logic [2:0] rise_cnt = '0;
  logic [2:0] fall_cnt = '0;  // bits already sent this byte
  logic [7:0] log_q[$];

  initial begin
    log_cnt   = 0;
    last_byte = '0;
  end

  // msb first, next bit after each falling edge
  assign miso = script_byte[3'd7 - fall_cnt];

  always @(posedge sck) begin
    logic [7:0] nxt;
    if (!card_cs_n) begin
      nxt = {in_sr[6:0], mosi};
      in_sr = nxt;
      if (rise_cnt == 3'd7) begin
        log_q.push_back(nxt);  // byte complete
        last_byte = nxt;
        log_cnt = log_q.size();
      end
      rise_cnt = rise_cnt + 3'd1;
    end
  end

  always @(negedge sck) begin
    if (!card_cs_n) begin
      fall_cnt = fall_cnt + 3'd1;  // wraps back to bit 7 after the byte
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic int_clk,
  output logic arst_n
);

  initial begin
    int_clk = 1'b0;
    forever #2 int_clk = ~int_clk;  // 4 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge int_clk);
    @(negedge int_clk);  // release away from the active edge
    arst_n = 1'b1;
  end

endmodule

// ==== tb_spi_card.sv ====
`timescale 1ns/1ps
`include "spi_card_cfg.svh"

module tb_spi_card;

  import spi_card_pkg::*;

  localparam int N_XFER = 12;  // per clock speed
  localparam int CYCLE_LIMIT = 40 * 16 * `SPI_DIV_SLOW + 2000;

  logic        int_clk;
  logic        arst_n;
  bus_req_t    bus_req;
  logic        miso;
  logic        sck;
  logic        mosi;
  logic        card_cs_n;
  byte_t       rdata;
  logic        d_oe;
  logic        n_rdy;
  byte_t       miso_script;
  int          log_cnt;
  byte_t       last_byte;
  string       test_name = "reset";
  int          seed = 32'h1e20_7dfc;
  int unsigned cycle_cnt = 0;

  // reference state built from the register map and transfer timing
  logic        wr_data;
  logic        wr_ctrl;
  logic        rd_any;
  logic        wr_accept;
  logic        launch_q;
  logic        exp_busy;
  logic        cs_ref;
  logic        slow_ref;
  int unsigned busy_left;
  int unsigned cur_div;
  int          exp_log_cnt;
  byte_t       rx_ref;
  byte_t       tx_pend;
  byte_t       tx_ref;
  byte_t       status_ref;
  byte_t       exp_rdata;
  logic        sck_q;
  int unsigned gap;
  int unsigned rises;

  tb_clk_gen clk_i (
    .int_clk (int_clk),
    .arst_n  (arst_n)
  );

  spi_card_top dut_i (
    .int_clk   (int_clk),
    .arst_n    (arst_n),
    .bus_req   (bus_req),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .card_cs_n (card_cs_n),
    .rdata     (rdata),
    .d_oe      (d_oe),
    .n_rdy     (n_rdy)
  );

  tb_card_model card_i (
    .sck         (sck),
    .mosi        (mosi),
    .card_cs_n   (card_cs_n),
    .script_byte (miso_script),
    .miso        (miso),
    .log_cnt     (log_cnt),
    .last_byte   (last_byte)
  );

  assign wr_data   = ~bus_req.n_sel & ~bus_req.n_we & (bus_req.addr == 1'(`SPI_ADDR_DATA));
  assign wr_ctrl   = ~bus_req.n_sel & ~bus_req.n_we & (bus_req.addr == 1'(`SPI_ADDR_CTRL));
  assign rd_any    = ~bus_req.n_sel & ~bus_req.n_oe;
  assign wr_accept = wr_data & ~exp_busy & ~launch_q;
  assign exp_busy  = (busy_left != 0);

  assign status_ref = {exp_busy, 5'b0_0000, slow_ref, cs_ref};
  assign exp_rdata  = (bus_req.addr == 1'(`SPI_ADDR_CTRL)) ? status_ref : rx_ref;

  // start one cycle after the write, busy one cycle later for 16 half periods
  always @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      launch_q    <= 1'b0;
      busy_left   <= 0;
      cur_div     <= `SPI_DIV_SLOW;
      cs_ref      <= 1'b0;
      slow_ref    <= 1'b1;
      rx_ref      <= '0;
      tx_pend     <= '0;
      tx_ref      <= '0;
      exp_log_cnt <= 0;
    end else begin
      launch_q <= wr_accept;
      if (wr_accept) tx_pend <= bus_req.wdata;
      if (wr_ctrl) begin
        cs_ref   <= bus_req.wdata[0];
        slow_ref <= bus_req.wdata[1];
      end
      if (launch_q) begin
        cur_div   <= slow_ref ? `SPI_DIV_SLOW : `SPI_DIV_FAST;
        busy_left <= 16 * (slow_ref ? `SPI_DIV_SLOW : `SPI_DIV_FAST);
      end else if (busy_left != 0) begin
        busy_left <= busy_left - 1;
        if (busy_left == 1) begin
          rx_ref      <= miso_script;
          tx_ref      <= tx_pend;
          exp_log_cnt <= exp_log_cnt + 1;
        end
      end
    end
  end

  // sck rising edges, spacing and count per transfer
  always @(posedge int_clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_q <= 1'b0;
      gap   <= 0;
      rises <= 0;
    end else begin
      sck_q <= sck;
      gap   <= (sck && !sck_q) ? 1 : gap + 1;
      if (launch_q) rises <= 0;
      else if (sck && !sck_q) rises <= rises + 1;
    end
  end

  always @(posedge int_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  task automatic report_mismatch(input string check, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Error: %s in test %s, expected %0h, actual %0h", check, test_name,
             exp_val, act_val);
    $display("Verification failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  a_wait: assert property (@(posedge int_clk) disable iff (!arst_n)
    n_rdy == (exp_busy && !bus_req.n_sel))
    else report_mismatch("wait line", $sampled(exp_busy && !bus_req.n_sel), $sampled(n_rdy));

  a_doe: assert property (@(posedge int_clk) disable iff (!arst_n) d_oe == rd_any)
    else report_mismatch("read enable", $sampled(rd_any), $sampled(d_oe));

  a_rdata: assert property (@(posedge int_clk) disable iff (!arst_n)
    rd_any |-> rdata == exp_rdata)
    else report_mismatch("read data", $sampled(exp_rdata), $sampled(rdata));

  a_cs: assert property (@(posedge int_clk) disable iff (!arst_n) card_cs_n == !cs_ref)
    else report_mismatch("chip select", $sampled(!cs_ref), $sampled(card_cs_n));

  a_sck_idle: assert property (@(posedge int_clk) disable iff (!arst_n) !exp_busy |-> !sck)
    else report_mismatch("sck idle level", 0, $sampled(sck));

  a_gap: assert property (@(posedge int_clk) disable iff (!arst_n)
    (sck && !sck_q && rises != 0) |-> gap == 2 * cur_div)
    else report_mismatch("sck period", $sampled(2 * cur_div), $sampled(gap));

  a_rises: assert property (@(posedge int_clk) disable iff (!arst_n)
    (busy_left == 1) |-> rises == 8)
    else report_mismatch("sck edge count", 8, $sampled(rises));

  a_log_cnt: assert property (@(posedge int_clk) disable iff (!arst_n)
    !exp_busy |-> log_cnt == exp_log_cnt)
    else report_mismatch("card byte count", $sampled(exp_log_cnt), $sampled(log_cnt));

  a_tx: assert property (@(posedge int_clk) disable iff (!arst_n)
    (!exp_busy && exp_log_cnt != 0) |-> last_byte == tx_ref)
    else report_mismatch("transmit byte", $sampled(tx_ref), $sampled(last_byte));

  // one bus cycle, selected whenever a strobe is low
  task automatic drive_access(input logic n_we, input logic n_oe, input logic addr,
                              input byte_t data);
    bus_req_t req;
    @(posedge int_clk);
    req.n_sel = n_we & n_oe;
    req.n_we  = n_we;
    req.n_oe  = n_oe;
    req.addr  = addr;
    req.wdata = data;
    bus_req <= req;
  endtask

  task automatic bus_write(input logic addr, input byte_t data);
    drive_access(1'b0, 1'b1, addr, data);
  endtask

  task automatic bus_read(input logic addr);
    drive_access(1'b1, 1'b0, addr, '0);
  endtask

  task automatic bus_idle();
    drive_access(1'b1, 1'b1, 1'b0, '0);
  endtask

  // hold the read until the wait line drops
  task automatic read_until_ready(input logic addr);
    bus_read(addr);
    @(negedge int_clk);
    while (n_rdy) @(negedge int_clk);
  endtask

  task automatic run_transfer(input byte_t tx, input byte_t rx);
    @(posedge int_clk);
    miso_script <= rx;
    bus_write(1'(`SPI_ADDR_DATA), tx);
    bus_idle();
    bus_read(1'(`SPI_ADDR_CTRL));            // busy bit set
    bus_write(1'(`SPI_ADDR_DATA), ~tx);      // dropped, busy
    bus_idle();
    read_until_ready(1'(`SPI_ADDR_DATA));
    bus_idle();
  endtask

  initial begin
    byte_t tx;
    byte_t rx;
    bus_req     <= '{n_sel: 1'b1, n_we: 1'b1, n_oe: 1'b1, addr: 1'b0, wdata: 8'h00};
    miso_script <= '0;
    @(posedge arst_n);
    repeat (2) @(posedge int_clk);

    test_name = "reset";
    bus_read(1'(`SPI_ADDR_CTRL));
    bus_idle();

    test_name = "chip select";
    bus_write(1'(`SPI_ADDR_CTRL), 8'h03);  // card selected, slow clock
    bus_idle();
    bus_read(1'(`SPI_ADDR_CTRL));
    bus_idle();

    test_name = "slow transfers";
    repeat (N_XFER) begin
      tx = $random(seed);
      rx = $random(seed);
      run_transfer(tx, rx);
    end

    test_name = "fast transfers";
    bus_write(1'(`SPI_ADDR_CTRL), 8'h01);
    bus_idle();
    repeat (N_XFER) begin
      tx = $random(seed);
      rx = $random(seed);
      run_transfer(tx, rx);
    end

    test_name = "chip select release";
    bus_write(1'(`SPI_ADDR_CTRL), 8'h00);
    bus_idle();
    bus_read(1'(`SPI_ADDR_CTRL));
    bus_idle();
    repeat (4) @(posedge int_clk);

    if (log_cnt == 2 * N_XFER && exp_log_cnt == 2 * N_XFER) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Card received %0d bytes but %0d transfers were run", log_cnt, 2 * N_XFER);
      $display("Verification failed");
      $fatal(1, "transfer count mismatch");
    end
  end

endmodule

// ==== vlog.f ====
+incdir+.
spi_card_pkg.sv
spi_bus_regs.sv
spi_clk_gen.sv
spi_shifter.sv
spi_card_top.sv
tb_clk_gen.sv
tb_card_model.sv
tb_spi_card.sv
